/* hw/rob_config.svh */
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// entry index bits, 64 entries
`define ROB_WIDTH 6

// result word carried by the CDB
`define ROB_DATA_WIDTH 32

// APB side
`define APB_ADDR_WIDTH 4

// register offsets
`define ROB_REG_CTRL    4'h0
`define ROB_REG_STATUS  4'h4
`define ROB_REG_RETIRED 4'h8

`endif

/* hw/rob_pkg.sv */
`default_nettype none

`include "rob_config.svh"

package rob_pkg;

    typedef logic [`ROB_WIDTH-1:0] rob_idx_t;

    typedef enum logic [1:0] {
        rob_type_alu    = 2'd0,
        rob_type_branch = 2'd1,
        rob_type_load   = 2'd2,
        rob_type_store  = 2'd3
    } rob_type_e;

    ////////////////////////////////////////////////////////////
    // pipeline side
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic            valid;
        rob_type_e       itype;
        logic [4:0]      areg;
        logic            w_reg;
        logic [31:0]     pc;
        rob_idx_t [1:0]  src_idx;
    } rob_dispatch_req_t;

    // source operands of one dispatched instruction
    typedef struct packed {
        rob_idx_t                        idx;
        logic [1:0][`ROB_DATA_WIDTH-1:0] src_data;
        logic [1:0]                      src_complete;
    } rob_dispatch_rsp_t;

    // ctrl bit 1 is exception, bit 0 is branch mispredict
    typedef struct packed {
        logic                       valid;
        rob_idx_t                   idx;
        logic [`ROB_DATA_WIDTH-1:0] data;
        logic [1:0]                 ctrl;
    } rob_cdb_t;

    typedef struct packed {
        logic                       valid;
        rob_type_e                  itype;
        logic [4:0]                 areg;
        logic                       w_reg;
        logic [31:0]                pc;
        logic [`ROB_DATA_WIDTH-1:0] data;
        logic [1:0]                 ctrl;
    } rob_commit_t;

    ////////////////////////////////////////////////////////////
    // table entries
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        rob_type_e   itype;
        logic [4:0]  areg;
        logic        w_reg;
        logic [31:0] pc;
    } rob_inst_entry_t;

    typedef struct packed {
        logic [`ROB_DATA_WIDTH-1:0] data;
        logic [1:0]                 ctrl;
    } rob_data_entry_t;

    ////////////////////////////////////////////////////////////
    // register block <-> core
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic enable;
        logic flush;
    } rob_ctrl_t;

    typedef struct packed {
        logic [`ROB_WIDTH:0] count;
        logic [1:0]          retired;
    } rob_status_t;

endpackage

`default_nettype wire

/* hw/rob_banked_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_banked_regfile import rob_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 64,
    parameter int R_PORTS    = 2
) (
    input  wire logic                                 clk,
    input  wire logic                                 arst_n_i,
    input  wire logic                                 clear_i,
    input  wire logic [1:0]                           we_i,
    input  wire rob_idx_t [1:0]                       waddr_i,
    input  wire logic [1:0][DATA_WIDTH-1:0]           wdata_i,
    input  wire rob_idx_t [R_PORTS-1:0]               raddr_i,
    output logic [R_PORTS-1:0][DATA_WIDTH-1:0]        rdata_o
);

    // rows per bank, bank picked by the low index bit
    localparam int HALF  = DEPTH / 2;
    localparam int ROW_W = $clog2(DEPTH) - 1;

    logic [DATA_WIDTH-1:0] bank_q [2][HALF];

    ////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////

    // consecutive dispatch slots land in different banks
    for (genvar b = 0; b < 2; b++) begin : g_bank
        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                for (int r = 0; r < HALF; r++) begin
                    bank_q[b][r] <= '0;
                end
            end else if (clear_i) begin
                for (int r = 0; r < HALF; r++) begin
                    bank_q[b][r] <= '0;
                end
            end else begin
                // later port overrides, so port 1 wins on a clash
                for (int p = 0; p < 2; p++) begin
                    if (we_i[p] && (waddr_i[p][0] == b[0])) begin
                        bank_q[b][waddr_i[p][ROW_W:1]] <= wdata_i[p];
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////

    // asynchronous reads, old contents until the edge
    always_comb begin
        for (int r = 0; r < R_PORTS; r++) begin
            rdata_o[r] = bank_q[raddr_i[r][0]][raddr_i[r][ROW_W:1]];
        end
    end

endmodule

`default_nettype wire

/* hw/rob_complete_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_complete_table import rob_pkg::*; (
    input  wire logic           clk,
    input  wire logic           arst_n_i,
    input  wire logic           clear_i,

    // allocation flips
    input  wire logic [1:0]     disp_we_i,
    input  wire rob_idx_t [1:0] disp_idx_i,

    // writeback flips
    input  wire logic [1:0]     cdb_we_i,
    input  wire rob_idx_t [1:0] cdb_idx_i,

    // four source reads, then two commit reads
    input  wire rob_idx_t [5:0] raddr_i,
    output logic [5:0]          complete_o
);

    localparam int ENTRIES = 1 << `ROB_WIDTH;

    logic [ENTRIES-1:0] disp_q;
    logic [ENTRIES-1:0] disp_d;
    logic [ENTRIES-1:0] cdb_q;
    logic [ENTRIES-1:0] cdb_d;

    ////////////////////////////////////////////////////////////
    // flip vectors
    ////////////////////////////////////////////////////////////

    // allocation makes the two bits differ, writeback brings them back
    always_comb begin
        disp_d = disp_q;
        cdb_d  = cdb_q;
        for (int p = 0; p < 2; p++) begin
            if (disp_we_i[p]) begin
                disp_d[disp_idx_i[p]] = ~disp_q[disp_idx_i[p]];
            end
            if (cdb_we_i[p]) begin
                cdb_d[cdb_idx_i[p]] = ~cdb_q[cdb_idx_i[p]];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            disp_q <= '0;
            cdb_q  <= '0;
        end else if (clear_i) begin
            disp_q <= '0;
            cdb_q  <= '0;
        end else begin
            disp_q <= disp_d;
            cdb_q  <= cdb_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // completion lookup
    ////////////////////////////////////////////////////////////

    // equal bits mean no writeback outstanding
    always_comb begin
        for (int r = 0; r < 6; r++) begin
            complete_o[r] = ~(disp_q[raddr_i[r]] ^ cdb_q[raddr_i[r]]);
        end
    end

endmodule

`default_nettype wire

/* hw/rob_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_core import rob_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    arst_n_i,
    input  wire rob_ctrl_t               ctrl_i,

    input  wire rob_dispatch_req_t [1:0] dispatch_i,
    output logic                         dispatch_ready_o,
    output rob_dispatch_rsp_t [1:0]      dispatch_rsp_o,

    input  wire rob_cdb_t [1:0]          cdb_i,

    output rob_commit_t [1:0]            commit_o,
    input  wire logic [1:0]              commit_ready_i,

    output rob_status_t                  status_o
);

    localparam int ENTRIES = 1 << `ROB_WIDTH;

    // head allocates, tail retires
    rob_idx_t            head_q;
    rob_idx_t            tail_q;
    logic [`ROB_WIDTH:0] count_q;

    logic [1:0]          disp_we;
    rob_idx_t [1:0]      alloc_idx;
    logic [1:0]          retire;
    logic [1:0]          n_alloc;
    logic [1:0]          n_ret;

    rob_inst_entry_t [1:0] inst_wr;
    rob_inst_entry_t [1:0] inst_rd;
    rob_data_entry_t [1:0] data_wr;
    rob_data_entry_t [5:0] data_rd;
    rob_idx_t [1:0]        cdb_idx;
    logic [1:0]            cdb_we;
    rob_idx_t [5:0]        rd_idx;
    logic [5:0]            complete;

    ////////////////////////////////////////////////////////////
    // allocation
    ////////////////////////////////////////////////////////////

    // two free slots needed, whatever the slot count
    assign dispatch_ready_o = ctrl_i.enable && !ctrl_i.flush &&
                              (count_q <= (`ROB_WIDTH+1)'(ENTRIES - 2));

    assign disp_we[0] = dispatch_ready_o && dispatch_i[0].valid;
    assign disp_we[1] = disp_we[0] && dispatch_i[1].valid;

    assign alloc_idx[0] = head_q;
    assign alloc_idx[1] = head_q + rob_idx_t'(1);

    ////////////////////////////////////////////////////////////
    // retire
    ////////////////////////////////////////////////////////////

    assign retire[0] = commit_o[0].valid && commit_ready_i[0];
    assign retire[1] = retire[0] && commit_o[1].valid && commit_ready_i[1];

    assign n_alloc = {1'b0, disp_we[0]} + {1'b0, disp_we[1]};
    assign n_ret   = {1'b0, retire[0]} + {1'b0, retire[1]};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (ctrl_i.flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + rob_idx_t'(n_alloc);
            tail_q  <= tail_q + rob_idx_t'(n_ret);
            count_q <= count_q + (`ROB_WIDTH+1)'(n_alloc) - (`ROB_WIDTH+1)'(n_ret);
        end
    end

    assign status_o.count   = count_q;
    assign status_o.retired = n_ret;

    ////////////////////////////////////////////////////////////
    // tables
    ////////////////////////////////////////////////////////////

    // src reads first, the two oldest entries last
    assign rd_idx = {tail_q + rob_idx_t'(1), tail_q,
                     dispatch_i[1].src_idx, dispatch_i[0].src_idx};

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            inst_wr[s].itype = dispatch_i[s].itype;
            inst_wr[s].areg  = dispatch_i[s].areg;
            inst_wr[s].w_reg = dispatch_i[s].w_reg;
            inst_wr[s].pc    = dispatch_i[s].pc;
            data_wr[s].data  = cdb_i[s].data;
            data_wr[s].ctrl  = cdb_i[s].ctrl;
            cdb_idx[s]       = cdb_i[s].idx;
            cdb_we[s]        = cdb_i[s].valid;
        end
    end

    rob_banked_regfile #(
        .DATA_WIDTH ($bits(rob_inst_entry_t)),
        .DEPTH      (ENTRIES),
        .R_PORTS    (2)
    ) inst_table_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .clear_i  (ctrl_i.flush),
        .we_i     (disp_we),
        .waddr_i  (alloc_idx),
        .wdata_i  (inst_wr),
        .raddr_i  (rd_idx[5:4]),
        .rdata_o  (inst_rd)
    );

    rob_banked_regfile #(
        .DATA_WIDTH ($bits(rob_data_entry_t)),
        .DEPTH      (ENTRIES),
        .R_PORTS    (6)
    ) data_table_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .clear_i  (ctrl_i.flush),
        .we_i     (cdb_we),
        .waddr_i  (cdb_idx),
        .wdata_i  (data_wr),
        .raddr_i  (rd_idx),
        .rdata_o  (data_rd)
    );

    rob_complete_table complete_table_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .clear_i    (ctrl_i.flush),
        .disp_we_i  (disp_we),
        .disp_idx_i (alloc_idx),
        .cdb_we_i   (cdb_we),
        .cdb_idx_i  (cdb_idx),
        .raddr_i    (rd_idx),
        .complete_o (complete)
    );

    ////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            dispatch_rsp_o[s].idx             = alloc_idx[s];
            dispatch_rsp_o[s].src_data[0]     = data_rd[2*s].data;
            dispatch_rsp_o[s].src_data[1]     = data_rd[2*s+1].data;
            dispatch_rsp_o[s].src_complete[0] = complete[2*s];
            dispatch_rsp_o[s].src_complete[1] = complete[2*s+1];
        end
        for (int k = 0; k < 2; k++) begin
            // idle entries read as complete, so occupancy gates valid
            commit_o[k].valid = (count_q > (`ROB_WIDTH+1)'(k)) && complete[4+k];
            commit_o[k].itype = inst_rd[k].itype;
            commit_o[k].areg  = inst_rd[k].areg;
            commit_o[k].w_reg = inst_rd[k].w_reg;
            commit_o[k].pc    = inst_rd[k].pc;
            commit_o[k].data  = data_rd[4+k].data;
            commit_o[k].ctrl  = data_rd[4+k].ctrl;
        end
    end

endmodule

`default_nettype wire

/* hw/rob_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_apb_regs import rob_pkg::*; (
    input  wire logic                       clk,
    input  wire logic                       arst_n_i,

    input  wire logic [`APB_ADDR_WIDTH-1:0] paddr_i,
    input  wire logic                       psel_i,
    input  wire logic                       penable_i,
    input  wire logic                       pwrite_i,
    input  wire logic [31:0]                pwdata_i,
    output logic [31:0]                     prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,

    input  wire rob_status_t                status_i,
    output rob_ctrl_t                       ctrl_o
);

    logic        enable_q;
    logic        flush_q;
    logic [31:0] retired_q;

    logic        access;
    logic        sel_ctrl;
    logic        sel_status;
    logic        sel_retired;

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    assign access      = psel_i && penable_i;
    assign sel_ctrl    = (paddr_i == `ROB_REG_CTRL);
    assign sel_status  = (paddr_i == `ROB_REG_STATUS);
    assign sel_retired = (paddr_i == `ROB_REG_RETIRED);

    // no wait states
    assign pready_o  = 1'b1;
    assign pslverr_o = access && !(sel_ctrl || sel_status || sel_retired);

    ////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            enable_q  <= 1'b0;
            flush_q   <= 1'b0;
            retired_q <= '0;
        end else begin
            // flush lasts one cycle after the access phase
            flush_q <= access && pwrite_i && sel_ctrl && pwdata_i[1];
            if (access && pwrite_i && sel_ctrl) begin
                enable_q <= pwdata_i[0];
            end
            // wraps, kept across flush
            retired_q <= retired_q + {30'd0, status_i.retired};
        end
    end

    assign ctrl_o.enable = enable_q;
    assign ctrl_o.flush  = flush_q;

    // read mux, flush bit reads as zero
    always_comb begin
        prdata_o = '0;
        if (psel_i && !pwrite_i) begin
            if (sel_ctrl) begin
                prdata_o = {31'd0, enable_q};
            end else if (sel_status) begin
                prdata_o = {{(32-`ROB_WIDTH-1){1'b0}}, status_i.count};
            end else if (sel_retired) begin
                prdata_o = retired_q;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rob_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_top import rob_pkg::*; (
    input  wire logic                       clk,
    input  wire logic                       arst_n_i,

    // pipeline
    input  wire rob_dispatch_req_t [1:0]    dispatch_i,
    output logic                            dispatch_ready_o,
    output rob_dispatch_rsp_t [1:0]         dispatch_rsp_o,
    input  wire rob_cdb_t [1:0]             cdb_i,
    output rob_commit_t [1:0]               commit_o,
    input  wire logic [1:0]                 commit_ready_i,

    // APB slave
    input  wire logic [`APB_ADDR_WIDTH-1:0] paddr_i,
    input  wire logic                       psel_i,
    input  wire logic                       penable_i,
    input  wire logic                       pwrite_i,
    input  wire logic [31:0]                pwdata_i,
    output logic [31:0]                     prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o
);

    rob_ctrl_t   ctrl;
    rob_status_t status;

    rob_apb_regs apb_regs_i (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .paddr_i   (paddr_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .status_i  (status),
        .ctrl_o    (ctrl)
    );

    rob_core core_i (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .ctrl_i           (ctrl),
        .dispatch_i       (dispatch_i),
        .dispatch_ready_o (dispatch_ready_o),
        .dispatch_rsp_o   (dispatch_rsp_o),
        .cdb_i            (cdb_i),
        .commit_o         (commit_o),
        .commit_ready_i   (commit_ready_i),
        .status_o         (status)
    );

endmodule

`default_nettype wire

/* verification/rob_model.svh */
`ifndef ROB_MODEL_SVH
`define ROB_MODEL_SVH

// one entry as the pipeline sees it
typedef struct packed {
    logic [1:0]  itype;
    logic [4:0]  areg;
    logic        w_reg;
    logic [31:0] pc;
    logic [31:0] data;
    logic [1:0]  ctrl;
    logic        done;
} model_entry_t;

// oldest entry at the front, model_tail is its index
model_entry_t model_q[$];
int           model_tail;
logic [31:0]  model_retired;
logic         model_enable;

function automatic int model_head();
    return (model_tail + model_q.size()) % ENTRIES;
endfunction

// queue position of an index, size or more when not allocated
function automatic int model_pos(input rob_idx_t idx);
    return (int'(idx) - model_tail + ENTRIES) % ENTRIES;
endfunction

function automatic void model_flush();
    model_q.delete();
    model_tail = 0;
endfunction

function automatic void model_push(input rob_dispatch_req_t req);
    model_entry_t e;
    e.itype = req.itype;
    e.areg  = req.areg;
    e.w_reg = req.w_reg;
    e.pc    = req.pc;
    e.data  = '0;
    e.ctrl  = '0;
    e.done  = 1'b0;
    model_q.push_back(e);
endfunction

function automatic void model_writeback(input rob_cdb_t wb);
    model_entry_t e;
    int           pos;
    pos     = model_pos(wb.idx);
    e       = model_q[pos];
    e.data  = wb.data;
    e.ctrl  = wb.ctrl;
    e.done  = 1'b1;
    model_q[pos] = e;
endfunction

// oldest first, the total survives a flush
function automatic void model_retire(input int n);
    repeat (n) begin
        void'(model_q.pop_front());
        model_tail    = (model_tail + 1) % ENTRIES;
        model_retired = model_retired + 32'd1;
    end
endfunction

`endif

/* verification/rob_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_tb import rob_pkg::*; ();

    localparam int ENTRIES           = 1 << `ROB_WIDTH;
    localparam int RESET_CYCLES      = 16;
    localparam int RANDOM_CYCLES     = 1500;
    localparam int FILL_LIMIT        = 80;
    localparam int DRAIN_LIMIT       = 300;
    localparam int PRE_FLUSH_CYCLES  = 40;
    localparam int POST_FLUSH_CYCLES = 300;
    localparam int APB_CYCLES        = 60;
    localparam int PLANNED_CYCLES    = RESET_CYCLES + RANDOM_CYCLES + FILL_LIMIT
                                     + DRAIN_LIMIT + PRE_FLUSH_CYCLES
                                     + POST_FLUSH_CYCLES + APB_CYCLES;

    logic                       clk;
    logic                       arst_n;
    rob_dispatch_req_t [1:0]    dispatch;
    logic                       dispatch_ready;
    rob_dispatch_rsp_t [1:0]    dispatch_rsp;
    rob_cdb_t [1:0]             cdb;
    rob_commit_t [1:0]          commit;
    logic [1:0]                 commit_ready;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [31:0]                pwdata;
    logic [31:0]                prdata;
    logic                       pready;
    logic                       pslverr;
    int                         seed;

    `include "rob_model.svh"

    rob_top dut_i (
        .clk              (clk),
        .arst_n_i         (arst_n),
        .dispatch_i       (dispatch),
        .dispatch_ready_o (dispatch_ready),
        .dispatch_rsp_o   (dispatch_rsp),
        .cdb_i            (cdb),
        .commit_o         (commit),
        .commit_ready_i   (commit_ready),
        .paddr_i          (paddr),
        .psel_i           (psel),
        .penable_i        (penable),
        .pwrite_i         (pwrite),
        .pwdata_i         (pwdata),
        .prdata_o         (prdata),
        .pready_o         (pready),
        .pslverr_o        (pslverr)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("error: %s is 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return int'((r & 32'h7fff_ffff) % n);
    endfunction

    task automatic drive_idle();
        dispatch     = '0;
        cdb          = '0;
        commit_ready = '0;
    endtask

    ////////////////////////////////////////////////////////////
    // APB master
    ////////////////////////////////////////////////////////////

    task automatic apb_write(input logic [`APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        @(negedge clk);
        drive_idle();
        paddr  = addr;
        pwrite = 1'b1;
        pwdata = data;
        psel   = 1'b1;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [`APB_ADDR_WIDTH-1:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge clk);
        drive_idle();
        paddr  = addr;
        pwrite = 1'b0;
        psel   = 1'b1;
        @(negedge clk);
        penable = 1'b1;
        #10;
        check("pready_o", 128'(pready), 128'(1));
        data = prdata;
        err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_expect(input logic [`APB_ADDR_WIDTH-1:0] addr, input string name,
                               input logic [31:0] exp);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check(name, 128'(data), 128'(exp));
        check("pslverr_o", 128'(err), 128'(0));
    endtask

    ////////////////////////////////////////////////////////////
    // one pipeline cycle: drive, check, step the model
    ////////////////////////////////////////////////////////////

    task automatic run_cycle(input int disp_pct, input logic hold_commit);
        int             pos;
        int             start;
        logic           accept;
        logic           exp_done;
        logic [1:0]     exp_valid;
        logic [1:0]     take;
        rob_idx_t       idx;
        rob_cdb_t [1:0] wb;
        rob_commit_t    exp_commit;
        @(negedge clk);
        for (int s = 0; s < 2; s++) begin
            dispatch[s].valid = rand_below(100) < disp_pct;
            dispatch[s].itype = rob_type_e'(2'(rand_below(4)));
            dispatch[s].areg  = 5'(rand_below(32));
            dispatch[s].w_reg = 1'(rand_below(2));
            dispatch[s].pc    = $random(seed);
            for (int j = 0; j < 2; j++) begin
                // lean toward occupied entries
                if (model_q.size() > 0 && rand_below(2) == 1) begin
                    idx = rob_idx_t'((model_tail + rand_below(model_q.size())) % ENTRIES);
                end else begin
                    idx = rob_idx_t'(rand_below(ENTRIES));
                end
                dispatch[s].src_idx[j] = idx;
            end
        end
        dispatch[1].valid = dispatch[1].valid && dispatch[0].valid;

        // writebacks to distinct allocated entries still waiting
        wb = '0;
        for (int s = 0; s < 2; s++) begin
            if (model_q.size() > 0 && rand_below(4) != 0) begin
                start = rand_below(model_q.size());
                for (int o = 0; o < model_q.size(); o++) begin
                    pos = (start + o) % model_q.size();
                    idx = rob_idx_t'((model_tail + pos) % ENTRIES);
                    if (!wb[s].valid && !model_q[pos].done &&
                        !(s == 1 && wb[0].valid && wb[0].idx == idx)) begin
                        wb[s].valid = 1'b1;
                        wb[s].idx   = idx;
                        wb[s].data  = $random(seed);
                        wb[s].ctrl  = 2'(rand_below(4));
                    end
                end
            end
        end
        cdb          = wb;
        commit_ready = hold_commit ? 2'b00 : 2'(rand_below(4));

        #10;
        accept = model_enable && (model_q.size() <= ENTRIES - 2);
        check("dispatch_ready_o", 128'(dispatch_ready), 128'(accept));
        for (int s = 0; s < 2; s++) begin
            check($sformatf("dispatch_rsp_o[%0d].idx", s), 128'(dispatch_rsp[s].idx),
                  128'((model_head() + s) % ENTRIES));
            for (int j = 0; j < 2; j++) begin
                pos      = model_pos(dispatch[s].src_idx[j]);
                exp_done = (pos >= model_q.size()) || model_q[pos].done;
                check($sformatf("dispatch_rsp_o[%0d].src_complete[%0d]", s, j),
                      128'(dispatch_rsp[s].src_complete[j]), 128'(exp_done));
                if (pos < model_q.size() && model_q[pos].done) begin
                    check($sformatf("dispatch_rsp_o[%0d].src_data[%0d]", s, j),
                          128'(dispatch_rsp[s].src_data[j]), 128'(model_q[pos].data));
                end
            end
        end
        for (int k = 0; k < 2; k++) begin
            exp_valid[k] = (model_q.size() > k) && model_q[k].done;
            check($sformatf("commit_o[%0d].valid", k), 128'(commit[k].valid),
                  128'(exp_valid[k]));
            if (exp_valid[k]) begin
                exp_commit.valid = 1'b1;
                exp_commit.itype = rob_type_e'(model_q[k].itype);
                exp_commit.areg  = model_q[k].areg;
                exp_commit.w_reg = model_q[k].w_reg;
                exp_commit.pc    = model_q[k].pc;
                exp_commit.data  = model_q[k].data;
                exp_commit.ctrl  = model_q[k].ctrl;
                check($sformatf("commit_o[%0d]", k), 128'(commit[k]), 128'(exp_commit));
            end
        end

        // state after the coming edge
        take[0] = exp_valid[0] && commit_ready[0];
        take[1] = take[0] && exp_valid[1] && commit_ready[1];
        for (int s = 0; s < 2; s++) begin
            if (wb[s].valid) begin
                model_writeback(wb[s]);
            end
        end
        model_retire(int'(take[0]) + int'(take[1]));
        for (int s = 0; s < 2; s++) begin
            if (accept && dispatch[s].valid) begin
                model_push(dispatch[s]);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rd;
        logic        err;
        int          n;
        seed    = 70;
        clk     = 1'b0;
        arst_n  = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        drive_idle();
        model_flush();
        model_retired = '0;
        model_enable  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // out of reset, everything idle
        #10;
        check("dispatch_ready_o", 128'(dispatch_ready), 128'(0));
        check("commit_o[0].valid", 128'(commit[0].valid), 128'(0));
        check("commit_o[1].valid", 128'(commit[1].valid), 128'(0));
        check("prdata_o", 128'(prdata), 128'(0));
        read_expect(`ROB_REG_CTRL, "CTRL", 32'd0);
        read_expect(`ROB_REG_STATUS, "STATUS", 32'd0);
        read_expect(`ROB_REG_RETIRED, "RETIRED", 32'd0);
        apb_read(4'hC, rd, err);
        check("pslverr_o", 128'(err), 128'(1));
        apb_write(`ROB_REG_CTRL, 32'd1);
        model_enable = 1'b1;

        repeat (RANDOM_CYCLES) run_cycle(70, 1'b0);

        // withhold commits until dispatch stalls
        n = 0;
        while (model_q.size() <= ENTRIES - 2) begin
            if (n == FILL_LIMIT) begin
                report_failure("reorder buffer never filled while commits were held");
            end
            run_cycle(100, 1'b1);
            n++;
        end
        run_cycle(100, 1'b1);
        read_expect(`ROB_REG_STATUS, "STATUS", 32'(model_q.size()));

        n = 0;
        while (model_q.size() > 0) begin
            if (n == DRAIN_LIMIT) begin
                report_failure("reorder buffer did not drain after commits resumed");
            end
            run_cycle(0, 1'b0);
            n++;
        end

        // flush with entries in flight
        repeat (PRE_FLUSH_CYCLES) run_cycle(80, 1'b1);
        apb_write(`ROB_REG_CTRL, 32'd3);
        #10;
        check("dispatch_ready_o", 128'(dispatch_ready), 128'(0));
        model_flush();
        read_expect(`ROB_REG_STATUS, "STATUS", 32'd0);
        check("commit_o[0].valid", 128'(commit[0].valid), 128'(0));
        check("commit_o[1].valid", 128'(commit[1].valid), 128'(0));
        read_expect(`ROB_REG_CTRL, "CTRL", 32'd1);

        repeat (POST_FLUSH_CYCLES) run_cycle(70, 1'b0);
        read_expect(`ROB_REG_RETIRED, "RETIRED", model_retired);

        $display("TEST OK");
        $finish;
    end

    // watchdog sized from the planned cycle count
    initial begin
        #((PLANNED_CYCLES + 200) * 100);
        report_failure("simulation timed out");
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+hw
+incdir+verification
hw/rob_pkg.sv
hw/rob_banked_regfile.sv
hw/rob_complete_table.sv
hw/rob_core.sv
hw/rob_apb_regs.sv
hw/rob_top.sv
verification/rob_tb.sv

/* run.sh */
#!/bin/sh
# build and run the reorder buffer testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module rob_tb -f files.f -o rob_sim &&
./obj_dir/rob_sim | tee /dev/stderr | grep -q "TEST OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
